/* sine_request_tests.txt */
# chan index expected_sample, all hex; sample is 16-bit two's complement
1 000 0000
2 3F0 7FF5
3 400 7FF5
4 800 0000
5 C00 800B
6 200 5A82
7 5F0 5A82
8 410 7FD8
9 810 FCDC
A C10 8028
B 100 30FB
B 10F 30FB
C A80 9593
D E40 B141
1 3FF 7FF5

/* src.f */
+incdir+.
sine_req_pkg.sv
spi_byte_master.sv
spi_request_fsm.sv
sine_lut.sv
sample_bank.sv
sine_request_top.sv
tb_spi_device.sv
tb_sine_request.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the sine request testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_sine_request -o tb_sine_request
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sine_request > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
    exit 0
fi
exit 1

/* tb_sine_request.sv */
/* Testbench for sine_request_top, reads sine_request_tests.txt from the project root.
   Each data line holds channel, index and expected sample in hex; # starts a comment */
`timescale 1ns/1ps
`include "sine_req_defs.svh"

module tb_sine_request import sine_req_pkg::*; ();

    logic               clk;
    logic               reset;
    logic               start;
    logic [3:0]         rd_chan;
    logic               spi_clk;
    logic               spi_cs_n;
    logic               spi_mosi;
    logic               spi_miso;
    logic               busy;
    logic               new_valid;
    sample_t            new_sample;
    logic signed [15:0] rd_value;
    logic [15:0]        dev_word;    // Loaded into the device per request
    logic [7:0]         last_edges;
    logic [7:0]         frames;

    logic [15:0] chan_exp [`NUM_CHANNELS]; // Last expected sample per channel
    int          strobe_count;             // o_new_valid pulses seen
    int          tests_run;
    int          seed;
    int          gap;
    int          fd;
    int          n_fields;
    int          ch;
    string       line;
    logic [31:0] chan_f;
    logic [31:0] idx_f;
    logic [31:0] exp_f;

    always #10 clk = ~clk; // 20 ns period

    sine_request_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .i_start     (start),
        .i_spi_miso  (spi_miso),
        .o_spi_clk   (spi_clk),
        .o_spi_cs_n  (spi_cs_n),
        .o_spi_mosi  (spi_mosi),
        .o_busy      (busy),
        .o_new_valid (new_valid),
        .o_new_sample(new_sample),
        .i_rd_chan   (rd_chan),
        .o_rd_value  (rd_value)
    );

    tb_spi_device spi_dev0 (
        .clk         (clk),
        .reset       (reset),
        .i_word      (dev_word),
        .i_spi_clk   (spi_clk),
        .i_spi_cs_n  (spi_cs_n),
        .o_spi_miso  (spi_miso),
        .o_last_edges(last_edges),
        .o_frames    (frames)
    );

    // Strobe counter, extra strobes from dropped starts show up here
    always @(posedge clk) begin
        if (reset) strobe_count <= 0;
        else if (new_valid) strobe_count <= strobe_count + 1;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        @(posedge clk);
        while (busy !== level) begin
            n++;
            if (n > 2000) stop_on_error($sformatf("Timed out waiting for o_busy to be %0b", level));
            @(posedge clk);
        end
    endtask

    task automatic wait_new_sample();
        int n;
        n = 0;
        @(posedge clk);
        while (new_valid !== 1'b1) begin
            n++;
            if (n > 2000) stop_on_error("Timed out after 2000 cycles waiting for o_new_valid");
            @(posedge clk);
        end
    endtask

    // One start, then a second one while busy that must be dropped
    task automatic send_request(input logic [15:0] word);
        @(posedge clk);
        dev_word <= word;
        start    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_busy(1'b1);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        start     = 1'b0;
        rd_chan   = '0;
        dev_word  = '0;
        seed      = 1489;
        tests_run = 0;
        for (int i = 0; i < `NUM_CHANNELS; i++) chan_exp[i] = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("o_spi_cs_n after reset", 32'(spi_cs_n), 32'd1);
        check_value("o_spi_clk after reset", 32'(spi_clk), 32'd0);
        check_value("o_spi_mosi after reset", 32'(spi_mosi), 32'd0);
        check_value("o_busy after reset", 32'(busy), 32'd0);

        fd = $fopen("sine_request_tests.txt", "r");
        if (fd == 0) stop_on_error("Cannot open sine_request_tests.txt");
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() == 0 || line.getc(0) == "#") continue; // Comment or blank
            n_fields = $sscanf(line, "%h %h %h", chan_f, idx_f, exp_f);
            if (n_fields != 3) continue;
            gap = $unsigned($random(seed)) % 8; // Idle gap of 0 to 7 cycles
            repeat (gap) @(posedge clk);
            send_request({chan_f[3:0], idx_f[11:0]});
            wait_new_sample();
            check_value("o_new_sample.chan_id", 32'(new_sample.chan_id), 32'(chan_f[3:0]));
            check_value("o_new_sample.value", 32'($unsigned(new_sample.value)),
                        32'(exp_f[15:0]));
            chan_exp[chan_f[3:0]] = exp_f[15:0];
            tests_run++;
            wait_busy(1'b0); // Frame closed, device has logged it
            check_value("SPI rising edges per frame", 32'(last_edges), 32'(`REQ_BYTES * 8));
            check_value("SPI frame count", 32'(frames), 32'(tests_run));
            check_value("o_new_valid count", strobe_count, tests_run);
        end
        $fclose(fd);
        if (tests_run == 0) stop_on_error("No test lines found in sine_request_tests.txt");

        // Read port, unwritten channels stay zero
        for (ch = 0; ch < `NUM_CHANNELS; ch++) begin
            @(posedge clk);
            rd_chan <= ch[3:0];
            @(posedge clk);
            check_value($sformatf("o_rd_value[%0d]", ch), 32'($unsigned(rd_value)),
                        32'(chan_exp[ch]));
        end
        $display("Verification passed");
        $finish;
    end

endmodule

/* tb_spi_device.sv */
/* Behavioral mode-0 SPI slave, sampled on the system clock.
   Shifts i_word out MSB first from the CS fall and counts rising SPI edges per frame */
`timescale 1ns/1ps

module tb_spi_device (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] i_word,       // Word sent in the next frame
    input  logic        i_spi_clk,
    input  logic        i_spi_cs_n,
    output logic        o_spi_miso,
    output logic [7:0]  o_last_edges, // Rising edges seen in the last closed frame
    output logic [7:0]  o_frames      // Closed frames since reset
);

    logic [15:0] shift_reg;  // Bits still to send
    logic        sclk_q;     // SPI clock one system clock ago
    logic        cs_n_q;
    logic [7:0]  edge_cnt;   // Rising edges in the open frame

    always @(posedge clk) begin
        if (reset) begin
            shift_reg    <= '0;
            sclk_q       <= 1'b0;
            cs_n_q       <= 1'b1;
            edge_cnt     <= '0;
            o_spi_miso   <= 1'b0;
            o_last_edges <= '0;
            o_frames     <= '0;
        end else begin
            sclk_q <= i_spi_clk;
            cs_n_q <= i_spi_cs_n;
            if (cs_n_q && !i_spi_cs_n) begin
                // CS fell, first bit goes out before any SPI edge
                o_spi_miso <= i_word[15];
                shift_reg  <= {i_word[14:0], 1'b0};
                edge_cnt   <= '0;
            end else if (!i_spi_cs_n) begin
                if (!sclk_q && i_spi_clk) begin
                    edge_cnt <= edge_cnt + 1'b1; // Master samples here
                end
                if (sclk_q && !i_spi_clk) begin
                    o_spi_miso <= shift_reg[15]; // Next bit on falling edge
                    shift_reg  <= {shift_reg[14:0], 1'b0};
                end
            end else if (!cs_n_q) begin
                // CS rose, frame closed
                o_last_edges <= edge_cnt;
                o_frames     <= o_frames + 1'b1;
            end
        end
    end

endmodule

/* sine_request_top.sv */
/* SPI request fetch, sine lookup and per-channel store.
   One request in flight; i_start while o_busy is high is ignored */
`timescale 1ns/1ps

module sine_request_top import sine_req_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_start,
    input  logic               i_spi_miso,
    output logic               o_spi_clk,
    output logic               o_spi_cs_n,
    output logic               o_spi_mosi,
    output logic               o_busy,
    output logic               o_new_valid,
    output sample_t            o_new_sample,
    input  logic [3:0]         i_rd_chan,
    output logic signed [15:0] o_rd_value
);

    logic      req_valid;
    req_word_u req;
    logic      smp_valid;
    sample_t   smp;

    spi_request_fsm u_fsm (
        .clk        (clk),
        .reset      (reset),
        .i_start    (i_start),
        .i_spi_miso (i_spi_miso),
        .o_spi_clk  (o_spi_clk),
        .o_spi_cs_n (o_spi_cs_n),
        .o_spi_mosi (o_spi_mosi),
        .o_busy     (o_busy),
        .o_req_valid(req_valid),
        .o_req      (req)
    );

    sine_lut u_lut (
        .clk        (clk),
        .reset      (reset),
        .i_req_valid(req_valid),
        .i_req      (req),
        .o_smp_valid(smp_valid), // One cycle after req_valid
        .o_smp      (smp)
    );

    sample_bank u_bank (
        .clk         (clk),
        .reset       (reset),
        .i_smp_valid (smp_valid),
        .i_smp       (smp),
        .i_rd_chan   (i_rd_chan),
        .o_rd_value  (o_rd_value),
        .o_new_valid (o_new_valid),
        .o_new_sample(o_new_sample)
    );

endmodule

/* sample_bank.sv */
/* Latest sample per channel, all cleared by reset.
   Read port is combinational; a write shows on it the cycle after i_smp_valid */
`timescale 1ns/1ps
`include "sine_req_defs.svh"

module sample_bank import sine_req_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_smp_valid,
    input  sample_t            i_smp,
    input  logic [3:0]         i_rd_chan,
    output logic signed [15:0] o_rd_value,
    output logic               o_new_valid,  // Strobe per stored sample
    output sample_t            o_new_sample
);

    logic signed [15:0] chan_regs [`NUM_CHANNELS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_CHANNELS; i++) begin
                chan_regs[i] <= '0;
            end
            o_new_valid <= 1'b0;
        end else begin
            o_new_valid <= i_smp_valid;
            if (i_smp_valid) begin
                chan_regs[i_smp.chan_id] <= i_smp.value; // Overwrites older sample
            end
        end
    end

    // Echo of what was just written, aligned with the strobe
    always_ff @(posedge clk) begin
        if (i_smp_valid) o_new_sample <= i_smp;
    end

    assign o_rd_value = chan_regs[i_rd_chan];

endmodule

/* sine_lut.sv */
/* Quarter-wave sine, 64 points per quadrant, amplitude 32767.
   Index bits [3:0] are ignored, no interpolation. One cycle latency */
`timescale 1ns/1ps

module sine_lut import sine_req_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      i_req_valid,
    input  req_word_u i_req,
    output logic      o_smp_valid,
    output sample_t   o_smp
);

    logic [1:0]  quad;     // Quadrant of the full period
    logic [5:0]  pos;      // Position inside the quadrant
    logic [5:0]  lut_addr;
    logic [15:0] mag;      // Unsigned quarter-wave magnitude

    assign quad     = i_req.fields.sin_index[11:10];
    assign pos      = i_req.fields.sin_index[9:4];
    assign lut_addr = quad[0] ? 6'd63 - pos : pos; // Falling quadrants read mirrored

    // round(32767 * sin(pi/2 * k/64))
    always_comb begin
        case (lut_addr)
            6'd0:  mag = 16'd0;
            6'd1:  mag = 16'd804;
            6'd2:  mag = 16'd1608;
            6'd3:  mag = 16'd2410;
            6'd4:  mag = 16'd3212;
            6'd5:  mag = 16'd4011;
            6'd6:  mag = 16'd4808;
            6'd7:  mag = 16'd5602;
            6'd8:  mag = 16'd6393;
            6'd9:  mag = 16'd7179;
            6'd10: mag = 16'd7962;
            6'd11: mag = 16'd8739;
            6'd12: mag = 16'd9512;
            6'd13: mag = 16'd10278;
            6'd14: mag = 16'd11039;
            6'd15: mag = 16'd11793;
            6'd16: mag = 16'd12539;
            6'd17: mag = 16'd13279;
            6'd18: mag = 16'd14010;
            6'd19: mag = 16'd14732;
            6'd20: mag = 16'd15446;
            6'd21: mag = 16'd16151;
            6'd22: mag = 16'd16846;
            6'd23: mag = 16'd17530;
            6'd24: mag = 16'd18204;
            6'd25: mag = 16'd18868;
            6'd26: mag = 16'd19519;
            6'd27: mag = 16'd20159;
            6'd28: mag = 16'd20787;
            6'd29: mag = 16'd21403;
            6'd30: mag = 16'd22005;
            6'd31: mag = 16'd22594;
            6'd32: mag = 16'd23170;
            6'd33: mag = 16'd23731;
            6'd34: mag = 16'd24279;
            6'd35: mag = 16'd24811;
            6'd36: mag = 16'd25329;
            6'd37: mag = 16'd25832;
            6'd38: mag = 16'd26319;
            6'd39: mag = 16'd26790;
            6'd40: mag = 16'd27245;
            6'd41: mag = 16'd27683;
            6'd42: mag = 16'd28105;
            6'd43: mag = 16'd28510;
            6'd44: mag = 16'd28898;
            6'd45: mag = 16'd29268;
            6'd46: mag = 16'd29621;
            6'd47: mag = 16'd29956;
            6'd48: mag = 16'd30273;
            6'd49: mag = 16'd30571;
            6'd50: mag = 16'd30852;
            6'd51: mag = 16'd31113;
            6'd52: mag = 16'd31356;
            6'd53: mag = 16'd31580;
            6'd54: mag = 16'd31785;
            6'd55: mag = 16'd31971;
            6'd56: mag = 16'd32137;
            6'd57: mag = 16'd32285;
            6'd58: mag = 16'd32412;
            6'd59: mag = 16'd32521;
            6'd60: mag = 16'd32609;
            6'd61: mag = 16'd32678;
            6'd62: mag = 16'd32728;
            6'd63: mag = 16'd32757;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) o_smp_valid <= 1'b0;
        else       o_smp_valid <= i_req_valid;
    end

    // Second half period is negative
    always_ff @(posedge clk) begin
        if (i_req_valid) begin
            o_smp.chan_id <= i_req.fields.chan_id;
            o_smp.value   <= quad[1] ? -mag : mag;
        end
    end

endmodule

/* spi_request_fsm.sv */
/* Fetches one 16-bit request per start with the high byte first.
   Start is taken in idle only; o_req keeps the last word until the next frame's first byte */
`timescale 1ns/1ps

module spi_request_fsm import sine_req_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      i_start,
    input  logic      i_spi_miso,
    output logic      o_spi_clk,
    output logic      o_spi_cs_n,
    output logic      o_spi_mosi,
    output logic      o_busy,
    output logic      o_req_valid, // Single-cycle pulse per frame
    output req_word_u o_req
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_FIRST   = 2'd1;
    localparam logic [1:0] ST_SECOND  = 2'd2;
    localparam logic [1:0] ST_WAIT_CS = 2'd3;

    logic [1:0] state;
    logic       frame_start;
    logic       byte_valid;
    logic [7:0] rx_byte;

    assign frame_start = (state == ST_IDLE) && i_start; // Same cycle as the start
    assign o_busy      = (state != ST_IDLE);

    spi_byte_master u_master (
        .clk          (clk),
        .reset        (reset),
        .i_frame_start(frame_start),
        .i_spi_miso   (i_spi_miso),
        .o_byte_valid (byte_valid),
        .o_byte       (rx_byte),
        .o_spi_clk    (o_spi_clk),
        .o_spi_cs_n   (o_spi_cs_n),
        .o_spi_mosi   (o_spi_mosi)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            o_req_valid <= 1'b0;
        end else begin
            o_req_valid <= 1'b0;
            case (state)
                ST_IDLE:    if (i_start) state <= ST_FIRST;
                ST_FIRST:   if (byte_valid) state <= ST_SECOND;
                ST_SECOND: begin
                    if (byte_valid) begin
                        state       <= ST_WAIT_CS;
                        o_req_valid <= 1'b1; // Word complete with the low byte
                    end
                end
                ST_WAIT_CS: if (o_spi_cs_n) state <= ST_IDLE; // Frame closed
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // Bytes land in arrival order
    always_ff @(posedge clk) begin
        if (byte_valid && state == ST_FIRST) o_req.bytes.hi <= rx_byte;
        if (byte_valid && state == ST_SECOND) o_req.bytes.lo <= rx_byte;
    end

endmodule

/* spi_byte_master.sv */
/* SPI mode-0 receive-only master (CPOL 0, CPHA 0) with MOSI held low.
   One frame start clocks in REQ_BYTES bytes MSB first under a single CS low.
   Starts while CS is low are dropped */
`timescale 1ns/1ps
`include "sine_req_defs.svh"

module spi_byte_master (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_frame_start, // One-cycle frame request
    input  logic       i_spi_miso,
    output logic       o_byte_valid,  // One pulse per received byte
    output logic [7:0] o_byte,
    output logic       o_spi_clk,
    output logic       o_spi_cs_n,
    output logic       o_spi_mosi
);

    localparam int HALF_W = $clog2(`SPI_CLKS_PER_HALF_BIT);
    localparam int BYTE_W = $clog2(`REQ_BYTES + 1);
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`SPI_CLKS_PER_HALF_BIT - 1);
    localparam logic [BYTE_W-1:0] BYTES_END = BYTE_W'(`REQ_BYTES);

    logic [HALF_W-1:0] half_cnt;  // Clocks within the current half bit
    logic [2:0]        bit_cnt;   // Bit within the byte that wraps after 7
    logic [BYTE_W-1:0] byte_cnt;  // Bytes completed in this frame
    logic [6:0]        shift_reg; // First 7 bits of the byte
    logic              half_done;

    assign half_done  = (half_cnt == HALF_LAST);
    assign o_spi_mosi = 1'b0; // Nothing to transmit

    // Frame, bit and byte sequencing
    always_ff @(posedge clk) begin
        if (reset) begin
            o_spi_cs_n   <= 1'b1;
            o_spi_clk    <= 1'b0;
            o_byte_valid <= 1'b0;
            half_cnt     <= '0;
            bit_cnt      <= '0;
            byte_cnt     <= '0;
        end else begin
            o_byte_valid <= 1'b0;
            if (o_spi_cs_n) begin
                if (i_frame_start) begin
                    o_spi_cs_n <= 1'b0; // Device drives first bit from here
                    half_cnt   <= '0;
                    bit_cnt    <= '0;
                    byte_cnt   <= '0;
                end
            end else if (!half_done) begin
                half_cnt <= half_cnt + 1'b1;
            end else begin
                half_cnt <= '0;
                if (!o_spi_clk) begin
                    // Rising edge where MISO has been stable for a half bit
                    o_spi_clk <= 1'b1;
                    bit_cnt   <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        o_byte_valid <= 1'b1;
                        byte_cnt     <= byte_cnt + 1'b1;
                    end
                end else begin
                    o_spi_clk <= 1'b0; // Falling edge lets the device shift
                    if (byte_cnt == BYTES_END) begin
                        o_spi_cs_n <= 1'b1; // Half bit after last rising edge
                    end
                end
            end
        end
    end

    // Receive shifter fills MSB first
    always_ff @(posedge clk) begin
        if (!o_spi_cs_n && half_done && !o_spi_clk) begin
            shift_reg <= {shift_reg[5:0], i_spi_miso};
            if (bit_cnt == 3'd7) begin
                o_byte <= {shift_reg, i_spi_miso}; // Eighth bit completes the byte
            end
        end
    end

endmodule

/* sine_req_pkg.sv */
/* Request word and sample types of the sine request path.
   Request word arrives MSB byte first: channel id in the top nibble */
package sine_req_pkg;

    // One 16-bit request, filled as bytes and read as fields
    typedef union packed {
        struct packed {
            logic [7:0] hi;        // First byte on the wire
            logic [7:0] lo;        // Second byte
        } bytes;
        struct packed {
            logic [3:0]  chan_id;   // Requesting channel
            logic [11:0] sin_index; // Table index, only [11:4] used
        } fields;
    } req_word_u;

    // Looked-up sample tagged with its channel
    typedef struct packed {
        logic [3:0]         chan_id;
        logic signed [15:0] value;
    } sample_t;

endpackage

/* sine_req_defs.svh */
/* SPI rate and frame size shared by the RTL and the testbench.
   Half-bit count must be 2 or more; the request FSM assembles exactly 2 bytes */
`ifndef SINE_REQ_DEFS_SVH
`define SINE_REQ_DEFS_SVH

// System clocks per half SPI bit (4 gives clk/8 on the SPI clock)
`define SPI_CLKS_PER_HALF_BIT 4

// Bytes clocked in per chip-select frame
`define REQ_BYTES 2

// Per-channel sample registers for the 4-bit channel id
`define NUM_CHANNELS 16

`endif
